// File: tests/reverb_stimulus.txt
# h v active pixel_in wet feedback stored_word | expected pixel_out write_word (hex)
# Frame 0 has wet and feedback at zero, frame 1 has wet full scale and feedback half.
0 0 1 C86428 000 000 FF00 C86428 6E50
1 0 1 28B478 000 000 FF00 28B478 8232
2 0 1 FF0000 000 000 FF00 FF0000 3F7F
3 0 1 0000FF 000 000 FF00 0000FF 3FC0
4 0 1 404040 000 000 FF00 404040 4000
5 0 1 808080 000 000 FF00 808080 8000
6 0 1 28B478 000 000 FF00 28B478 82D8
7 0 1 C86428 000 000 FF00 C86428 6EF6
8 0 0 000000 000 000 0000 000000 0000
9 0 0 000000 000 000 0000 000000 0000
0 1 1 C86428 000 000 FF00 C86428 6E50
1 1 1 28B478 000 000 FF00 28B478 8232
2 1 1 FF0000 000 000 FF00 FF0000 3F7F
3 1 1 0000FF 000 000 FF00 0000FF 3FC0
4 1 1 404040 000 000 FF00 404040 4000
5 1 1 808080 000 000 FF00 808080 8000
6 1 1 28B478 000 000 FF00 28B478 82D8
7 1 1 C86428 000 000 FF00 C86428 6EF6
8 1 0 000000 000 000 0000 000000 0000
9 1 0 000000 000 000 0000 000000 0000
0 2 1 C86428 000 000 0000 C86428 6E50
1 2 1 28B478 000 000 0000 28B478 8232
2 2 1 FF0000 000 000 0000 FF0000 3F7F
3 2 1 0000FF 000 000 0000 0000FF 3FC0
4 2 1 404040 000 000 0000 404040 4000
5 2 1 808080 000 000 0000 808080 8000
6 2 1 28B478 000 000 0000 28B478 82D8
7 2 1 C86428 000 000 0000 C86428 6EF6
8 2 0 000000 000 000 0000 000000 0000
9 2 0 000000 000 000 0000 000000 0000
0 0 1 820032 3FF 200 6E50 828632 4E28
1 0 1 820032 3FF 200 8232 909A40 53F9
2 0 1 505050 3FF 200 C800 C7C7C7 6400
3 0 1 505050 3FF 200 C800 C7C7C7 6400
4 0 1 F0F0F0 3FF 200 C800 F0F0F0 F000
5 0 1 F0F0F0 3FF 200 C800 F0F0F0 F000
6 0 1 505050 3FF 200 C800 C7C7C7 6400
7 0 1 505050 3FF 200 C800 C7C7C7 6400
8 0 0 000000 3FF 200 0000 000000 0000
9 0 0 000000 3FF 200 0000 000000 0000
0 1 1 820032 3FF 200 6E50 828632 4E28
1 1 1 820032 3FF 200 8232 909A40 53F9
2 1 1 505050 3FF 200 C800 C7C7C7 6400
3 1 1 505050 3FF 200 C800 C7C7C7 6400
4 1 1 F0F0F0 3FF 200 C800 F0F0F0 F000
5 1 1 F0F0F0 3FF 200 C800 F0F0F0 F000
6 1 1 505050 3FF 200 C800 C7C7C7 6400
7 1 1 505050 3FF 200 C800 C7C7C7 6400
8 1 0 000000 3FF 200 0000 000000 0000
9 1 0 000000 3FF 200 0000 000000 0000
0 2 1 820032 3FF 200 6E50 828632 4E28
1 2 1 820032 3FF 200 8232 909A40 53F9
2 2 1 505050 3FF 200 C800 C7C7C7 6400
3 2 1 505050 3FF 200 C800 C7C7C7 6400
4 2 1 F0F0F0 3FF 200 C800 F0F0F0 F000
5 2 1 F0F0F0 3FF 200 C800 F0F0F0 F000
6 2 1 505050 3FF 200 C800 C7C7C7 6400
7 2 1 505050 3FF 200 C800 C7C7C7 6400
8 2 0 000000 3FF 200 0000 000000 0000
9 2 0 000000 3FF 200 0000 000000 0000

// File: compile.f
design/reverb_pkg.sv
design/ycocg_422_decoder.sv
design/reverb_channel_mixer.sv
design/ycocg_422_encoder.sv
design/reverb_write_timer.sv
design/video_reverb.sv
tests/tb_video_reverb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the video reverb testbench with Verilator.
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing -Wno-fatal --top-module tb_video_reverb \
  -f compile.f -o tb_video_reverb_sim 2>&1 && ./obj_dir/tb_video_reverb_sim 2>&1)
echo "$out"

echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// File: tests/tb_video_reverb.sv
`timescale 1ns/100ps

module tb_video_reverb import reverb_pkg::*; ();

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_IDLE     = 3;
  localparam int FLUSH_CYCLES = 12;
  localparam int MAX_LINES    = 128;
  localparam int H_ACTIVE     = 8;
  localparam int V_ACTIVE     = 3;
  localparam int READ_LATENCY = 1;
  localparam int PIXEL_DELAY  = READ_LATENCY + 5;
  localparam int WORD_DELAY   = READ_LATENCY + 8;

  logic        clk;
  logic        rst_n;
  raster_t     raster_in;
  rgb_t        pixel_in;
  ctrl_t       ctrl;
  ycocg_word_t read_word;
  raster_t     raster_out;
  rgb_t        pixel_out;
  raster_t     read_raster;
  ycocg_word_t write_word;
  logic        write_valid;
  logic        write_last;

  raster_t     line_raster [MAX_LINES];
  rgb_t        line_pixel  [MAX_LINES];
  ctrl_t       line_ctrl   [MAX_LINES];
  ycocg_word_t line_stored [MAX_LINES];
  rgb_t        exp_pixel   [MAX_LINES];
  ycocg_word_t exp_word    [MAX_LINES];
  logic        exp_last    [MAX_LINES];
  int          n_lines;
  int          cyc; // Index of the line being driven, -1 before the first.
  logic        loaded;

  video_reverb #(
    .H_ACTIVE     (H_ACTIVE),
    .V_ACTIVE     (V_ACTIVE),
    .READ_LATENCY (READ_LATENCY)
  ) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .raster_in   (raster_in),
    .pixel_in    (pixel_in),
    .ctrl        (ctrl),
    .read_word   (read_word),
    .raster_out  (raster_out),
    .pixel_out   (pixel_out),
    .read_raster (read_raster),
    .write_word  (write_word),
    .write_valid (write_valid),
    .write_last  (write_last)
  );

  always #(PERIOD/2) clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("sim failed");
    $fatal(1);
  endtask

  // A frame ends on its H_ACTIVE * V_ACTIVE-th active line.
  task automatic mark_frame_ends();
    int active_seen;
    active_seen = 0;
    for (int i = 0; i < n_lines; i++) begin
      exp_last[i] = 1'b0;
      if (line_raster[i].active_draw) begin
        active_seen++;
        if (active_seen == H_ACTIVE * V_ACTIVE) begin
          exp_last[i] = 1'b1;
          active_seen = 0;
        end
      end
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_h, f_v, f_act, f_pix, f_wet, f_fb, f_st, f_ep, f_ew;
    fd = $fopen("tests/reverb_stimulus.txt", "r");
    if (fd == 0) begin
      $display("The stimulus file tests/reverb_stimulus.txt could not be opened.");
      $display("sim failed");
      $fatal(1);
    end
    n_lines = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f_h, f_v, f_act, f_pix, f_wet, f_fb, f_st, f_ep, f_ew);
        if (cnt == 9 && n_lines < MAX_LINES) begin
          line_raster[n_lines] = '{h_count: f_h[10:0], v_count: f_v[9:0],
                                   active_draw: f_act[0]};
          line_pixel[n_lines]  = f_pix[23:0];
          line_ctrl[n_lines]   = '{wet: f_wet[9:0], feedback: f_fb[9:0]};
          line_stored[n_lines] = f_st[15:0];
          exp_pixel[n_lines]   = f_ep[23:0];
          exp_word[n_lines]    = f_ew[15:0];
          n_lines++;
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int idle;
    clk       = 1'b0;
    rst_n     = 1'b0;
    raster_in = '0;
    pixel_in  = '0;
    ctrl      = '0;
    read_word = '0;
    cyc       = -1;
    loaded    = 1'b0;
    void'($urandom(41));
    load_stimulus();
    mark_frame_ends();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    idle = $urandom % (MAX_IDLE + 1); // Idle gap before the first frame.
    repeat (idle) @(posedge clk);
    for (int k = 0; k < n_lines + FLUSH_CYCLES; k++) begin
      @(posedge clk);
      #1;
      cyc = k;
      if (k < n_lines) begin
        raster_in = line_raster[k];
        pixel_in  = line_pixel[k];
        ctrl      = line_ctrl[k];
      end else begin
        raster_in = '0;
        pixel_in  = '0;
      end
      // Frame store answers one cycle after the address.
      if (k >= 1 && k - 1 < n_lines) begin
        read_word = line_stored[k-1];
      end else begin
        read_word = '0;
      end
    end
    @(posedge clk);
    $display("sim passed");
    $finish;
  end

  always @(negedge clk) begin
    int p;
    int w;
    p = cyc - PIXEL_DELAY;
    w = cyc - WORD_DELAY;
    if (rst_n && cyc < 0) begin
      assert (!write_valid && !write_last && !raster_out.active_draw)
        else stop_on_error("write strobes or active_draw high before the first frame");
    end else if (rst_n) begin
      if (cyc < n_lines) begin
        assert (read_raster == line_raster[cyc])
          else stop_on_error($sformatf("read_raster %h, expected %h (line %0d)",
                                       read_raster, line_raster[cyc], cyc));
      end
      if (p >= 0 && p < n_lines) begin
        assert (raster_out == line_raster[p])
          else stop_on_error($sformatf("raster_out %h, expected %h (line %0d)",
                                       raster_out, line_raster[p], p));
        assert (pixel_out == exp_pixel[p])
          else stop_on_error($sformatf("pixel_out %h, expected %h (line %0d)",
                                       pixel_out, exp_pixel[p], p));
      end else if (p < 0) begin
        assert (raster_out == '0)
          else stop_on_error($sformatf("raster_out %h, expected zero", raster_out));
      end
      if (w >= 0 && w < n_lines) begin
        assert (write_valid == line_raster[w].active_draw)
          else stop_on_error($sformatf("write_valid %b, expected %b (line %0d)",
                                       write_valid, line_raster[w].active_draw, w));
        assert (write_last == exp_last[w])
          else stop_on_error($sformatf("write_last %b, expected %b (line %0d)",
                                       write_last, exp_last[w], w));
        if (line_raster[w].active_draw) begin
          assert (write_word == exp_word[w])
            else stop_on_error($sformatf("write_word %h, expected %h (line %0d)",
                                         write_word, exp_word[w], w));
        end
      end else if (w < 0) begin
        assert (!write_valid && !write_last)
          else stop_on_error($sformatf("write strobes high at cycle %0d", cyc));
      end
    end
  end

  // Reset, idle gap, file lines, flush and a margin.
  initial begin
    wait (loaded);
    #((RESET_CYCLES + MAX_IDLE + n_lines + FLUSH_CYCLES + 20) * PERIOD);
    $display("Timeout: the simulation did not reach its end in time.");
    $display("sim failed");
    $fatal(1);
  end

endmodule

// File: design/video_reverb.sv
`timescale 1ns/100ps

module video_reverb import reverb_pkg::*; #(
  parameter int H_ACTIVE     = 1280,
  parameter int V_ACTIVE     = 720,
  parameter int READ_LATENCY = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  raster_t     raster_in,
  input  rgb_t        pixel_in,
  input  ctrl_t       ctrl,
  input  ycocg_word_t read_word,
  output raster_t     raster_out,
  output rgb_t        pixel_out,
  output raster_t     read_raster,
  output ycocg_word_t write_word,
  output logic        write_valid,
  output logic        write_last
);

  localparam int FRONT_STAGES = READ_LATENCY + DECODE_LATENCY;

  raster_t         front_raster [FRONT_STAGES];
  rgb_t            front_pixel  [FRONT_STAGES];
  raster_t         back_raster  [MIX_LATENCY];
  rgb_t            feedback_pixel;
  rgb_t            new_feedback_pixel;
  logic [2:0][7:0] wet_bytes;
  logic [2:0][7:0] feed_bytes;

  assign read_raster = raster_in; // Frame store sees the live position.

  // Live pixel waits for the store read and the decoder.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FRONT_STAGES; i++) begin
        front_raster[i] <= '0;
        front_pixel[i]  <= '0;
      end
    end else begin
      front_raster[0] <= raster_in;
      front_pixel[0]  <= pixel_in;
      for (int i = 1; i < FRONT_STAGES; i++) begin
        front_raster[i] <= front_raster[i-1];
        front_pixel[i]  <= front_pixel[i-1];
      end
    end
  end

  // Raster rides alongside the mixers.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MIX_LATENCY; i++) begin
        back_raster[i] <= '0;
      end
    end else begin
      back_raster[0] <= front_raster[FRONT_STAGES-1];
      for (int i = 1; i < MIX_LATENCY; i++) begin
        back_raster[i] <= back_raster[i-1];
      end
    end
  end

  assign raster_out = back_raster[MIX_LATENCY-1];

  ycocg_422_decoder i_decoder (
    .clk   (clk),
    .rst_n (rst_n),
    .word  (read_word),
    .odd   (front_raster[READ_LATENCY-1].h_count[0]), // Parity of the returned word.
    .pixel (feedback_pixel)
  );

  for (genvar i = 0; i < 3; i++) begin : g_lane
    reverb_channel_mixer i_mixer (
      .clk      (clk),
      .rst_n    (rst_n),
      .live     (front_pixel[FRONT_STAGES-1][8*i +: 8]),
      .stored   (feedback_pixel[8*i +: 8]),
      .ctrl     (ctrl),
      .wet_out  (wet_bytes[i]),
      .feed_out (feed_bytes[i])
    );
  end

  assign pixel_out          = rgb_t'(wet_bytes);
  assign new_feedback_pixel = rgb_t'(feed_bytes);

  ycocg_422_encoder i_encoder (
    .clk   (clk),
    .rst_n (rst_n),
    .pixel (new_feedback_pixel),
    .odd   (raster_out.h_count[0]),
    .word  (write_word)
  );

  reverb_write_timer #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) i_write_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .raster (raster_out),
    .valid  (write_valid),
    .last   (write_last)
  );

endmodule

// File: design/reverb_write_timer.sv
`timescale 1ns/100ps

module reverb_write_timer import reverb_pkg::*; #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic    clk,
  input  logic    rst_n,
  input  raster_t raster,
  output logic    valid,
  output logic    last
);

  logic [ENCODE_LATENCY-1:0] valid_pipe;
  logic [ENCODE_LATENCY-1:0] last_pipe;
  logic                      frame_end;

  // Last drawn pixel of the frame.
  assign frame_end = raster.active_draw &&
                     raster.h_count == 11'(H_ACTIVE - 1) &&
                     raster.v_count == 10'(V_ACTIVE - 1);

  // Strobes track the encoder depth.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
      last_pipe  <= '0;
    end else begin
      valid_pipe <= {valid_pipe[ENCODE_LATENCY-2:0], raster.active_draw};
      last_pipe  <= {last_pipe[ENCODE_LATENCY-2:0], frame_end};
    end
  end

  assign valid = valid_pipe[ENCODE_LATENCY-1];
  assign last  = last_pipe[ENCODE_LATENCY-1];

endmodule

// File: design/ycocg_422_encoder.sv
`timescale 1ns/100ps

module ycocg_422_encoder import reverb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  rgb_t        pixel,
  input  logic        odd,
  output ycocg_word_t word
);

  logic signed [8:0] co_d;
  logic signed [8:0] tmp_d;
  logic signed [8:0] cg_d;
  logic signed [8:0] y_d;

  logic signed [8:0] co_q;
  logic signed [8:0] tmp_q;
  logic [7:0]        g_q;
  logic              odd_q;

  logic [7:0]        y_q;
  logic signed [7:0] chroma_q;

  // First lifting step on the incoming pixel.
  assign co_d  = $signed({1'b0, pixel.r}) - $signed({1'b0, pixel.b});
  assign tmp_d = $signed({1'b0, pixel.b}) + (co_d >>> 1);

  // Second lifting step, Y always lands in 0 to 255.
  assign cg_d = $signed({1'b0, g_q}) - tmp_q;
  assign y_d  = tmp_q + (cg_d >>> 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      co_q  <= '0;
      tmp_q <= '0;
      g_q   <= '0;
      odd_q <= 1'b0;
    end else begin
      co_q  <= co_d;
      tmp_q <= tmp_d;
      g_q   <= pixel.g;
      odd_q <= odd;
    end
  end

  // Halved chroma, Co on even columns and Cg on odd.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y_q      <= '0;
      chroma_q <= '0;
    end else begin
      y_q      <= y_d[7:0];
      chroma_q <= odd_q ? cg_d[8:1] : co_q[8:1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word <= '0;
    end else begin
      word.y <= y_q;
      word.c <= chroma_q;
    end
  end

endmodule

// File: design/reverb_channel_mixer.sv
`timescale 1ns/100ps

module reverb_channel_mixer import reverb_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] live,
  input  logic [7:0] stored,
  input  ctrl_t      ctrl,
  output logic [7:0] wet_out,
  output logic [7:0] feed_out
);

  logic [15:0] wet_prod;
  logic [15:0] feed_prod;
  logic [7:0]  live_q;
  logic [7:0]  wet_scaled;
  logic [7:0]  feed_scaled;

  // Upper byte of the amount gives a 0 to 255/256 gain.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wet_prod  <= '0;
      feed_prod <= '0;
      live_q    <= '0;
    end else begin
      wet_prod  <= ctrl.wet[9:2] * stored;
      feed_prod <= ctrl.feedback[9:2] * stored;
      live_q    <= live;
    end
  end

  assign wet_scaled  = wet_prod[15:8];
  assign feed_scaled = feed_prod[15:8];

  // Brighter of the two wins.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wet_out  <= '0;
      feed_out <= '0;
    end else begin
      wet_out  <= (wet_scaled > live_q) ? wet_scaled : live_q;
      feed_out <= (feed_scaled > live_q) ? feed_scaled : live_q;
    end
  end

endmodule

// File: design/ycocg_422_decoder.sv
`timescale 1ns/100ps

module ycocg_422_decoder import reverb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  ycocg_word_t word,
  input  logic        odd,
  output rgb_t        pixel
);

  ycocg_word_t       even_word;
  logic signed [9:0] co_in;
  logic signed [9:0] cg_in;
  logic signed [9:0] co_q;
  logic signed [9:0] cg_q;
  logic signed [9:0] tmp_even;
  logic signed [9:0] tmp_odd;
  logic              pair_q;
  rgb_t              odd_pending;

  function automatic logic [7:0] clamp8(input logic signed [9:0] v);
    if (v < 0) begin
      return 8'd0;
    end
    if (v > 10'sd255) begin
      return 8'd255;
    end
    return v[7:0];
  endfunction

  function automatic rgb_t rebuild(input logic signed [9:0] tmp,
                                   input logic signed [9:0] co,
                                   input logic signed [9:0] cg);
    logic signed [9:0] b;
    rgb_t              p;
    b   = tmp - (co >>> 1);
    p.g = clamp8(cg + tmp);
    p.b = clamp8(b);
    p.r = clamp8(b + co);
    return p;
  endfunction

  assign co_in = $signed(even_word.c);
  assign cg_in = $signed(word.c); // Only meaningful while odd is high.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      even_word <= '0;
      co_q      <= '0;
      cg_q      <= '0;
      tmp_even  <= '0;
      tmp_odd   <= '0;
      pair_q    <= 1'b0;
    end else begin
      if (!odd) begin
        even_word <= word; // Wait for the odd partner.
      end
      pair_q   <= odd;
      co_q     <= co_in;
      cg_q     <= cg_in;
      tmp_even <= $signed({2'b00, even_word.y}) - (cg_in >>> 1);
      tmp_odd  <= $signed({2'b00, word.y}) - (cg_in >>> 1);
    end
  end

  // Even pixel leaves at once, the odd one a cycle later.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pixel       <= '0;
      odd_pending <= '0;
    end else if (pair_q) begin
      pixel       <= rebuild(tmp_even, co_q, cg_q);
      odd_pending <= rebuild(tmp_odd, co_q, cg_q);
    end else begin
      pixel <= odd_pending;
    end
  end

endmodule

// File: design/reverb_pkg.sv
package reverb_pkg;

  // Position of one raster sample and whether it is drawn.
  typedef struct packed {
    logic [10:0] h_count;
    logic [9:0]  v_count;
    logic        active_draw;
  } raster_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // Stored 4:2:2 word, c is Co on even columns and Cg on odd ones.
  typedef struct packed {
    logic [7:0]        y;
    logic signed [7:0] c;
  } ycocg_word_t;

  // User amounts, full scale is 10'h3ff.
  typedef struct packed {
    logic [9:0] wet;
    logic [9:0] feedback;
  } ctrl_t;

  localparam int DECODE_LATENCY = 3; // Read word to rebuilt pixel.
  localparam int MIX_LATENCY    = 2; // Channel mixer depth.
  localparam int ENCODE_LATENCY = 3; // Feedback pixel to write word.

endpackage
